// ==== src/decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// data path word
`define XLEN 32

// architectural register index
`define REG_IDX_W 5

// 16-bit compressed encoding
`define CINST_W 16

// x8..x15 reached from the 3-bit rvc register fields
`define RVC_REG_BASE 8

`endif

// ==== src/decode_pkg.sv ====
`include "decode_defs.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    ////////////////////////////////////////////////////////////
    // decoded operation, all ones marks an invalid word
    typedef enum logic [4:0] {
        OP_ADD,
        OP_AND,
        OP_OR,
        OP_SLL,
        OP_SRL,
        OP_SLT,
        OP_SLTU,
        OP_SRA,
        OP_SUB,
        OP_XOR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_INVALID = 5'b11111
    } op_e;

    // rv32i major opcodes, bits 6:0 of the word
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    ////////////////////////////////////////////////////////////
    typedef struct packed {
        word_t instr;      // always a 32-bit encoding
        logic  illegal;
        logic  compressed; // came in as a 16-bit word
    } expanded_t;

    typedef struct packed {
        op_e      op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     has_imm;
    } decoded_t;

endpackage

// ==== src/rvc_expander.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module rvc_expander (
    input  decode_pkg::word_t     instr,
    output decode_pkg::expanded_t expanded
);
    import decode_pkg::*;

    logic [`CINST_W-1:0] c;
    logic                is_c;
    reg_idx_t            rd_full;   // ci / cr register field
    reg_idx_t            rs2_full;
    reg_idx_t            rs1_p;     // c[9:7] mapped onto x8..x15
    reg_idx_t            rs2_p;     // c[4:2] mapped onto x8..x15
    logic [11:0]         ci_imm;
    logic [11:0]         clw_off;
    logic [20:0]         cj_off;

    assign c        = instr[`CINST_W-1:0];
    assign is_c     = (instr[1:0] != 2'b11);
    assign rd_full  = c[11:7];
    assign rs2_full = c[6:2];
    assign rs1_p    = reg_idx_t'(c[9:7]) + reg_idx_t'(`RVC_REG_BASE);
    assign rs2_p    = reg_idx_t'(c[4:2]) + reg_idx_t'(`RVC_REG_BASE);

    assign ci_imm  = {{6{c[12]}}, c[12], c[6:2]};
    assign clw_off = {5'b0, c[5], c[12:10], c[6], 2'b00}; // word scaled, unsigned
    assign cj_off  = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

    ////////////////////////////////////////////////////////////
    // kept subset rebuilt as rv32i words, everything else flagged
    always_comb begin
        expanded            = '0;
        expanded.compressed = is_c;
        if (!is_c) begin
            expanded.instr = instr;
        end else begin
            case ({c[1:0], c[15:13]})
                5'b01_000: begin // c.addi
                    expanded.instr = {ci_imm, rd_full, 3'b000, rd_full, OPC_OP_IMM};
                end
                5'b01_010: begin // c.li
                    expanded.instr = {ci_imm, 5'd0, 3'b000, rd_full, OPC_OP_IMM};
                end
                5'b01_101: begin // c.j
                    expanded.instr = {cj_off[20], cj_off[10:1], cj_off[11],
                                      cj_off[19:12], 5'd0, OPC_JAL};
                end
                5'b00_010: begin // c.lw
                    expanded.instr = {clw_off, rs1_p, 3'b010, rs2_p, OPC_LOAD};
                end
                5'b00_110: begin // c.sw
                    expanded.instr = {clw_off[11:5], rs2_p, rs1_p, 3'b010,
                                      clw_off[4:0], OPC_STORE};
                end
                5'b10_100: begin
                    if (rs2_full == '0) begin
                        // c.jr, jr x0 is reserved, c.jalr and c.ebreak not kept
                        if (c[12] || rd_full == '0)
                            expanded.illegal = 1'b1;
                        else
                            expanded.instr = {12'b0, rd_full, 3'b000, 5'd0, OPC_JALR};
                    end else if (!c[12]) begin // c.mv
                        expanded.instr = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, OPC_OP};
                    end else begin // c.add
                        expanded.instr = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
                    end
                end
                default: expanded.illegal = 1'b1;
            endcase
        end
    end

    // upper half only matters for a 32-bit word
    always_comb begin
        if (!$isunknown(instr[15:0]) && !$isunknown(instr[31:16] & {16{&instr[1:0]}})) begin
            a_out_known: assert #0 (!$isunknown(expanded))
                else $error("rvc_expander: unknown output for known input %h", instr);
        end
    end

endmodule

// ==== src/instr_stage.sv ====
`timescale 1ns/1ns

module instr_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  decode_pkg::expanded_t in_data,
    output logic                  stage_valid,
    output decode_pkg::expanded_t stage_data
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // held between strobes
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage_data <= in_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // a strobe always carries a fully known word into the stage
    a_known_strobe: assert property (
        @(posedge clk) disable iff (!rst)
        in_valid |-> !$isunknown(in_data)
    ) else $error("instr_stage: unknown data captured on a strobe");

endmodule

// ==== src/rv32_decoder.sv ====
`timescale 1ns/1ns

module rv32_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stage_valid,
    input  decode_pkg::expanded_t stage_data,
    output logic                  out_valid,
    output decode_pkg::decoded_t  out_dec
);
    import decode_pkg::*;

    localparam decoded_t DEC_NONE = '{op: OP_INVALID, default: '0};

    word_t      w;
    logic [2:0] f3;
    logic       alt;     // funct7 bit 30, sub / sra
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_sh;
    decoded_t   dec_next;

    assign w   = stage_data.instr;
    assign f3  = w[14:12];
    assign alt = w[30];

    ////////////////////////////////////////////////////////////
    // immediates per format
    assign imm_i  = {{20{w[31]}}, w[31:20]};
    assign imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    assign imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u  = {w[31:12], 12'b0};
    assign imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    assign imm_sh = {27'b0, w[24:20]}; // shamt

    always_comb begin
        dec_next = DEC_NONE;
        case (opcode_e'(w[6:0]))
            OPC_LUI, OPC_AUIPC: begin
                dec_next.op      = (w[5]) ? OP_LUI : OP_AUIPC;
                dec_next.rd      = w[11:7];
                dec_next.imm     = imm_u;
                dec_next.has_imm = 1'b1;
            end
            OPC_JAL: begin
                dec_next.op      = OP_JAL;
                dec_next.rd      = w[11:7];
                dec_next.imm     = imm_j;
                dec_next.has_imm = 1'b1;
            end
            OPC_JALR: begin
                if (f3 == 3'b000)
                    dec_next.op = OP_JALR;
                dec_next.rs1     = w[19:15];
                dec_next.rd      = w[11:7];
                dec_next.imm     = imm_i;
                dec_next.has_imm = 1'b1;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  dec_next.op = OP_BEQ;
                    3'b001:  dec_next.op = OP_BNE;
                    3'b100:  dec_next.op = OP_BLT;
                    3'b101:  dec_next.op = OP_BGE;
                    3'b110:  dec_next.op = OP_BLTU;
                    3'b111:  dec_next.op = OP_BGEU;
                    default: dec_next.op = OP_INVALID;
                endcase
                dec_next.rs1     = w[19:15];
                dec_next.rs2     = w[24:20];
                dec_next.imm     = imm_b;
                dec_next.has_imm = 1'b1;
            end
            OPC_LOAD: begin
                case (f3)
                    3'b000:  dec_next.op = OP_LB;
                    3'b001:  dec_next.op = OP_LH;
                    3'b010:  dec_next.op = OP_LW;
                    3'b100:  dec_next.op = OP_LBU;
                    3'b101:  dec_next.op = OP_LHU;
                    default: dec_next.op = OP_INVALID;
                endcase
                dec_next.rs1     = w[19:15];
                dec_next.rd      = w[11:7];
                dec_next.imm     = imm_i;
                dec_next.has_imm = 1'b1;
            end
            OPC_STORE: begin
                case (f3)
                    3'b000:  dec_next.op = OP_SB;
                    3'b001:  dec_next.op = OP_SH;
                    3'b010:  dec_next.op = OP_SW;
                    default: dec_next.op = OP_INVALID;
                endcase
                dec_next.rs1     = w[19:15];
                dec_next.rs2     = w[24:20];
                dec_next.imm     = imm_s;
                dec_next.has_imm = 1'b1;
            end
            OPC_OP_IMM: begin
                case (f3)
                    3'b000: dec_next.op = OP_ADD;
                    3'b001: dec_next.op = OP_SLL;
                    3'b010: dec_next.op = OP_SLT;
                    3'b011: dec_next.op = OP_SLTU;
                    3'b100: dec_next.op = OP_XOR;
                    3'b101: dec_next.op = (alt) ? OP_SRA : OP_SRL;
                    3'b110: dec_next.op = OP_OR;
                    3'b111: dec_next.op = OP_AND;
                endcase
                dec_next.rs1     = w[19:15];
                dec_next.rd      = w[11:7];
                dec_next.imm     = (f3[1:0] == 2'b01) ? imm_sh : imm_i;
                dec_next.has_imm = 1'b1;
            end
            OPC_OP: begin // register form, imm stays zero
                case (f3)
                    3'b000: dec_next.op = (alt) ? OP_SUB : OP_ADD;
                    3'b001: dec_next.op = OP_SLL;
                    3'b010: dec_next.op = OP_SLT;
                    3'b011: dec_next.op = OP_SLTU;
                    3'b100: dec_next.op = OP_XOR;
                    3'b101: dec_next.op = (alt) ? OP_SRA : OP_SRL;
                    3'b110: dec_next.op = OP_OR;
                    3'b111: dec_next.op = OP_AND;
                endcase
                dec_next.rs1 = w[19:15];
                dec_next.rs2 = w[24:20];
                dec_next.rd  = w[11:7];
            end
            default: dec_next = DEC_NONE;
        endcase
        // rejected by the expander, zero word or bad funct3
        if (stage_data.illegal || w == '0 || dec_next.op == OP_INVALID)
            dec_next = DEC_NONE;
    end

    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            out_dec   <= DEC_NONE;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid)
                out_dec <= dec_next;
        end
    end

    a_invalid_no_imm: assert property (
        @(posedge clk) disable iff (!rst)
        out_dec.op == OP_INVALID |-> !out_dec.has_imm
    ) else $error("rv32_decoder: has_imm set on an invalid op");

    // the expander only ever hands over full 32-bit encodings
    a_rvc_expanded: assert property (
        @(posedge clk) disable iff (!rst)
        stage_valid && stage_data.compressed && !stage_data.illegal
            |-> stage_data.instr[1:0] == 2'b11
    ) else $error("rv32_decoder: compressed word not expanded");

endmodule

// ==== src/decode_top.sv ====
`timescale 1ns/1ns

module decode_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  decode_pkg::word_t    in_instr,
    output logic                 out_valid,
    output decode_pkg::decoded_t out_dec
);
    import decode_pkg::*;

    expanded_t exp_word;
    logic      stage_valid;
    expanded_t stage_data;

    // combinational, same cycle as the strobe
    rvc_expander u_expander (
        .instr    (in_instr),
        .expanded (exp_word)
    );

    instr_stage u_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_data     (exp_word),
        .stage_valid (stage_valid),
        .stage_data  (stage_data)
    );

    rv32_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .out_valid   (out_valid),
        .out_dec     (out_dec)
    );

endmodule

// ==== test/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

`include "decode_defs.svh"

word_t rng_state = 32'h83d2c382;

// two lcg steps, upper halves only since the low bits cycle fast
function automatic word_t lcg_next();
    word_t hi;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    hi        = rng_state;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {hi[31:16], rng_state[31:16]};
endfunction

function automatic int rand_below(input int n);
    return int'(lcg_next() % n);
endfunction

// eight ops packed five bits each, entry 0 in the low bits
function automatic op_e op_from(input logic [39:0] tbl, input logic [2:0] f3);
    return op_e'(tbl[f3*5 +: 5]);
endfunction

////////////////////////////////////////////////////////////
// expected decode of a full 32-bit word
function automatic decoded_t rv32_expect(input word_t w);
    decoded_t   d;
    logic [2:0] f3;
    f3        = w[14:12];
    d         = '0;
    d.has_imm = 1'b1;
    case (w[6:0])
        7'b0110111: d.op = OP_LUI;
        7'b0010111: d.op = OP_AUIPC;
        7'b1101111: d.op = OP_JAL;
        7'b1100111: d.op = (f3 == 3'b000) ? OP_JALR : OP_INVALID;
        7'b1100011: d.op = op_from({OP_BGEU, OP_BLTU, OP_BGE, OP_BLT,
                                    OP_INVALID, OP_INVALID, OP_BNE, OP_BEQ}, f3);
        7'b0000011: d.op = op_from({OP_INVALID, OP_INVALID, OP_LHU, OP_LBU,
                                    OP_INVALID, OP_LW, OP_LH, OP_LB}, f3);
        7'b0100011: d.op = op_from({{5{OP_INVALID}}, OP_SW, OP_SH, OP_SB}, f3);
        7'b0010011, 7'b0110011: begin
            d.op = op_from({OP_AND, OP_OR, OP_SRL, OP_XOR,
                            OP_SLTU, OP_SLT, OP_SLL, OP_ADD}, f3);
            if (f3 == 3'b101 && w[30])
                d.op = OP_SRA;
            if (f3 == 3'b000 && w[30] && w[5]) // sub only in register form
                d.op = OP_SUB;
        end
        default: d.op = OP_INVALID;
    endcase
    case (w[6:0])
        7'b0110111, 7'b0010111: begin
            d.rd  = w[11:7];
            d.imm = {w[31:12], 12'h000};
        end
        7'b1101111: begin
            d.rd  = w[11:7];
            d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        end
        7'b1100011: begin
            d.rs1 = w[19:15];
            d.rs2 = w[24:20];
            d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        end
        7'b0100011: begin
            d.rs1 = w[19:15];
            d.rs2 = w[24:20];
            d.imm = 32'($signed({w[31:25], w[11:7]}));
        end
        7'b0110011: begin
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
            d.rd      = w[11:7];
            d.has_imm = 1'b0;
        end
        default: begin // i format, shifts take a plain shamt
            d.rs1 = w[19:15];
            d.rd  = w[11:7];
            d.imm = 32'($signed(w[31:20]));
            if (w[6:0] == 7'b0010011 && f3[1:0] == 2'b01)
                d.imm = {27'b0, w[24:20]};
        end
    endcase
    if (d.op == OP_INVALID || w == '0) begin
        d    = '0;
        d.op = OP_INVALID;
    end
    return d;
endfunction

// compressed words map straight onto the fields of their expansion
function automatic decoded_t rvc_expect(input logic [15:0] c);
    decoded_t d;
    reg_idx_t rp1;
    reg_idx_t rp2;
    word_t    lw_off;
    rp1    = reg_idx_t'(`RVC_REG_BASE + c[9:7]);
    rp2    = reg_idx_t'(`RVC_REG_BASE + c[4:2]);
    lw_off = {25'b0, c[5], c[12:10], c[6], 2'b00};
    d      = '0;
    d.op   = OP_INVALID;
    case ({c[15:13], c[1:0]})
        5'b000_01, 5'b010_01: begin // c.addi and c.li
            d.op      = OP_ADD;
            d.rd      = c[11:7];
            d.rs1     = (c[14]) ? 5'd0 : c[11:7];
            d.imm     = 32'($signed({c[12], c[6:2]}));
            d.has_imm = 1'b1;
        end
        5'b101_01: begin
            d.op      = OP_JAL;
            d.imm     = 32'($signed({c[12], c[8], c[10:9], c[6], c[7], c[2],
                                     c[11], c[5:3], 1'b0}));
            d.has_imm = 1'b1;
        end
        5'b010_00: begin
            d.op      = OP_LW;
            d.rd      = rp2;
            d.rs1     = rp1;
            d.imm     = lw_off;
            d.has_imm = 1'b1;
        end
        5'b110_00: begin
            d.op      = OP_SW;
            d.rs1     = rp1;
            d.rs2     = rp2;
            d.imm     = lw_off;
            d.has_imm = 1'b1;
        end
        5'b100_10: begin
            if (c[6:2] != 5'd0) begin // c.mv, c.add
                d.op  = OP_ADD;
                d.rd  = c[11:7];
                d.rs1 = (c[12]) ? c[11:7] : 5'd0;
                d.rs2 = c[6:2];
            end else if (!c[12] && c[11:7] != 5'd0) begin
                d.op      = OP_JALR;
                d.rs1     = c[11:7];
                d.has_imm = 1'b1;
            end
        end
        default: ;
    endcase
    return d;
endfunction

function automatic decoded_t expected_dec(input word_t w);
    if (w[1:0] == 2'b11)
        return rv32_expect(w);
    return rvc_expect(w[15:0]);
endfunction

////////////////////////////////////////////////////////////
function automatic word_t rv32_word();
    word_t      w;
    logic [2:0] f3;
    w  = lcg_next();
    f3 = w[14:12];
    case (rand_below(9))
        0: w[6:0] = 7'b0110111;
        1: w[6:0] = 7'b0010111;
        2: w[6:0] = 7'b1101111;
        3: w[14:0] = {3'b000, w[11:7], 7'b1100111};
        4: begin // funct3 2 and 3 fold onto beq and bne
            w[6:0] = 7'b1100011;
            w[13]  = w[13] & ~f3[2] ? 1'b0 : w[13];
        end
        5: begin
            w[6:0] = 7'b0000011;
            if (f3 == 3'd3 || f3 >= 3'd6)
                w[14:12] = 3'b010;
        end
        6: begin
            w[6:0]   = 7'b0100011;
            w[14:12] = 3'(f3 % 3);
        end
        7: begin
            w[6:0] = 7'b0010011;
            if (f3[1:0] == 2'b01)
                w[31:25] = {1'b0, f3[2] & w[30], 5'b0};
        end
        default: begin
            w[6:0]   = 7'b0110011;
            w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, w[30], 5'b0} : 7'b0;
        end
    endcase
    return w;
endfunction

// upper half left random, it must be ignored
function automatic word_t rvc_word();
    word_t w;
    w = lcg_next();
    case (rand_below(8))
        0: w[15:0] = {3'b000, w[12:2], 2'b01};
        1: w[15:0] = {3'b010, w[12:2], 2'b01};
        2: w[15:0] = {3'b101, w[12:2], 2'b01};
        3: w[15:0] = {3'b010, w[12:2], 2'b00};
        4: w[15:0] = {3'b110, w[12:2], 2'b00};
        5: begin // c.jr, x0 is reserved
            w[15:0] = {4'b1000, w[11:7], 7'b0000010};
            if (w[11:7] == 5'd0)
                w[7] = 1'b1;
        end
        default: begin
            w[15:0] = {3'b100, w[12:2], 2'b10};
            if (w[6:2] == 5'd0)
                w[2] = 1'b1;
        end
    endcase
    return w;
endfunction

function automatic word_t illegal_word();
    word_t       w;
    logic [27:0] opc;
    logic [49:0] drop;
    logic [4:0]  sel;
    w    = lcg_next();
    opc  = {7'b0001111, 7'b1110011, 7'b0101111, 7'b1010011};
    // c.jal c.lui c.addi4spn c.lwsp c.swsp c.slli alu group c.beqz c.bnez c.flw
    drop = {5'b001_01, 5'b011_01, 5'b000_00, 5'b010_10, 5'b110_10,
            5'b000_10, 5'b100_01, 5'b110_01, 5'b111_01, 5'b011_00};
    sel  = drop[rand_below(10)*5 +: 5];
    case (rand_below(6))
        0: w = '0;
        1: w[6:0] = opc[rand_below(4)*7 +: 7];
        2: w[14:0] = {2'b01, w[12:7], 7'b1100011};
        3: w[14:0] = {1'b1, w[13:7], (w[31]) ? 7'b0100011 : 7'b1100111};
        4: w[14:0] = {2'b11, w[12:7], 7'b0000011};
        default: w[15:0] = {sel[4:2], w[12:2], sel[1:0]};
    endcase
    return w;
endfunction

// kind 3 mixes the other three
function automatic word_t pick_word(input int kind);
    case ((kind == 3) ? rand_below(3) : kind)
        0: return rv32_word();
        1: return rvc_word();
        default: return illegal_word();
    endcase
endfunction

`endif

// ==== test/tb_decode.sv ====
`timescale 1ns/1ns

module tb_decode;
    import decode_pkg::*;

    `include "decode_model.svh"

    localparam int N_RV32  = 300;
    localparam int N_RVC   = 200;
    localparam int N_BAD   = 60;
    localparam int N_MIX   = 100;
    localparam int N_TOTAL = N_RV32 + N_RVC + N_BAD + N_MIX;

    typedef struct packed {
        decoded_t    dec;
        word_t       word;
        logic [31:0] cyc;
    } pend_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    word_t       in_instr;
    logic        out_valid;
    decoded_t    out_dec;

    pend_t       pending[$];
    logic [31:0] cyc = '0;
    int          errors;
    int          checks;
    int          tests;
    string       cur_test;

    decode_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_dec   (out_dec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////
    // outputs settle after the rising edge and are compared on the falling one
    always @(negedge clk) begin : check_out
        pend_t p;
        if (out_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("%s: out_valid seen with no strobe pending", cur_test);
                errors++;
            end else begin
                p = pending.pop_front();
                checks++;
                if (cyc - p.cyc != 2) begin
                    $display("Fail %s latency: expected 2 actual %0d", cur_test, cyc - p.cyc);
                    errors++;
                end
                if (out_dec !== p.dec) begin
                    $display("Fail %s: instr %h expected %h actual %h",
                             cur_test, p.word, p.dec, out_dec);
                    errors++;
                end
            end
        end
    end

    task automatic check_idle(input int cycles);
        int err0;
        err0     = errors;
        cur_test = "reset_idle";
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("Fail reset_idle: expected out_valid 0 actual %b", out_valid);
                errors++;
            end
            if (out_dec.op !== OP_INVALID) begin
                $display("Fail reset_idle: expected op %h actual op %h", OP_INVALID, out_dec.op);
                errors++;
            end
        end
        tests++;
        $display("test reset_idle done: %0d errors", errors - err0);
    endtask

    task automatic run_stream(input string name, input int kind, input int count,
                              input bit gaps);
        int    err0;
        int    idle;
        word_t w;
        pend_t p;
        err0     = errors;
        cur_test = name;
        @(negedge clk);
        for (int n = 0; n < count; n++) begin
            w      = pick_word(kind);
            p.dec  = expected_dec(w);
            p.word = w;
            p.cyc  = cyc;
            pending.push_back(p);
            in_valid = 1'b1;
            in_instr = w;
            @(negedge clk);
            idle = gaps ? rand_below(4) : 0;
            repeat (idle) begin
                in_valid = 1'b0;
                in_instr = lcg_next(); // junk while idle
                @(negedge clk);
            end
        end
        in_valid = 1'b0;
        repeat (6) begin
            if (pending.size() != 0)
                @(negedge clk);
        end
        if (pending.size() != 0) begin
            $display("%s: %0d strobes never got an out_valid", name, pending.size());
            errors += pending.size();
            pending.delete();
        end
        tests++;
        $display("test %s done: %0d strobes, %0d errors", name, count, errors - err0);
    endtask

    // each strobe takes at most four cycles including gaps
    initial begin
        repeat (N_TOTAL * 4 + 200) @(posedge clk);
        $display("watchdog: simulation did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst      = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        cur_test = "reset";
        repeat (3) @(negedge clk);
        rst = 1'b1;
        check_idle(5);
        run_stream("rv32_back_to_back", 0, N_RV32, 1'b0);
        run_stream("rvc_random_gaps", 1, N_RVC, 1'b1);
        run_stream("illegal_random_gaps", 2, N_BAD, 1'b1);
        run_stream("mixed_back_to_back", 3, N_MIX, 1'b0);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+src
+incdir+test
src/decode_pkg.sv
src/rvc_expander.sv
src/instr_stage.sv
src/rv32_decoder.sv
src/decode_top.sv
test/tb_decode.sv

// ==== Bender.yml ====
package:
  name: decode

sources:
  - include_dirs:
      - src
    files:
      - src/decode_pkg.sv
      - src/rvc_expander.sv
      - src/instr_stage.sv
      - src/rv32_decoder.sv
      - src/decode_top.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/tb_decode.sv
